//--- compile.f
logic/uart_str_pkg.sv
logic/str_chan_if.sv
logic/uart_bit_tx.sv
logic/uart_bit_rx.sv
logic/str_channel.sv
logic/str_dispatch.sv
logic/str_collect.sv
logic/uart_str_hub.sv
sim/tb_clk_gen.sv
sim/hub_checker.sv
sim/hub_sva.sv
sim/tb_uart_str_hub.sv

//--- logic/str_chan_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per channel bundle, transmit request
// and received frame, with modports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

interface str_chan_if
	import uart_str_pkg::*;
();
	// transmit group
	logic [STR_BITS-1:0] tx_string;
	logic [LEN_BITS-1:0] tx_length;
	logic                tx_req;
	logic                tx_busy;
	logic                tx_done;

	// receive group, held until the next frame
	logic [STR_BITS-1:0] rx_string;
	logic [LEN_BITS-1:0] rx_length;
	logic                rx_done;

	modport chan (
		input  tx_string, tx_length, tx_req,
		output tx_busy, tx_done, rx_string, rx_length, rx_done
	);

	modport disp (
		output tx_string, tx_length, tx_req,
		input  tx_busy, tx_done
	);

	modport coll (
		input rx_string, rx_length, rx_done
	);

endinterface

//--- logic/str_channel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one string channel
// transmit framing fsm, receive parsing
// fsm with idle timeout, bit tx and rx
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module str_channel
	import uart_str_pkg::*;
(
	input  logic     sys_clk,
	input  logic     sys_rst_n,
	str_chan_if.chan bus,
	input  logic     uart_rx,
	output logic     uart_tx
);

	logic [2:0]                         tx_state;
	str_buf_u                           tx_buf;
	logic [LEN_BITS-1:0]                tx_len;
	logic [$clog2(MAX_STR_BYTES)-1:0]   tx_idx;
	logic                               tx_last;
	logic                               tx_accept;
	logic                               bit_start;
	logic [7:0]                         bit_data;
	logic                               bit_done;

	logic [2:0]                         rx_state;
	str_buf_u                           rx_buf;
	logic [LEN_BITS-1:0]                rx_cnt;
	logic [$clog2(MAX_STR_BYTES)-1:0]   rx_wr_idx;
	logic [$clog2(RX_TIMEOUT_CLKS)-1:0] rx_idle_cnt;
	logic                               rx_timeout;
	logic [7:0]                         byte_data;
	logic                               byte_valid;

	assign tx_accept   = (tx_state == TX_IDLE) && bus.tx_req && (bus.tx_length != '0);
	assign tx_last     = (LEN_BITS'(tx_idx) + 1'b1 == tx_len);
	assign bus.tx_busy = (tx_state != TX_IDLE);
	assign bus.tx_done = (tx_state == TX_CLOSE2) && bit_done;

	// next byte is handed over in the done cycle of the previous one
	always_comb begin
		bit_start = 1'b0;
		bit_data  = BRACE_OPEN;
		case (tx_state)
			TX_IDLE:    bit_start = tx_accept;
			TX_OPEN1:   bit_start = bit_done;
			TX_OPEN2: begin
				bit_start = bit_done;
				bit_data  = tx_buf.bytes[0];
			end
			TX_CONTENT: begin
				bit_start = bit_done;
				bit_data  = tx_last ? BRACE_CLOSE : tx_buf.bytes[tx_idx + 1'b1];
			end
			TX_CLOSE1: begin
				bit_start = bit_done;
				bit_data  = BRACE_CLOSE;
			end
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_state <= TX_IDLE;
			tx_len   <= '0;
			tx_idx   <= '0;
		end else begin
			case (tx_state)
				TX_IDLE: if (tx_accept) begin
					tx_state <= TX_OPEN1;
					tx_idx   <= '0;
					tx_len   <= (bus.tx_length > MAX_STR_BYTES) ?
					            LEN_BITS'(MAX_STR_BYTES) : bus.tx_length;
				end
				TX_OPEN1:   if (bit_done) tx_state <= TX_OPEN2;
				TX_OPEN2:   if (bit_done) tx_state <= TX_CONTENT;
				TX_CONTENT: if (bit_done) begin
					if (tx_last)
						tx_state <= TX_CLOSE1;
					else
						tx_idx <= tx_idx + 1'b1;
				end
				TX_CLOSE1:  if (bit_done) tx_state <= TX_CLOSE2;
				TX_CLOSE2:  if (bit_done) tx_state <= TX_IDLE;
				default:    tx_state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (tx_accept)
			tx_buf.flat <= bus.tx_string;
	end

	assign rx_wr_idx  = rx_cnt[$clog2(MAX_STR_BYTES)-1:0];
	assign rx_timeout = (rx_state != RX_IDLE) && (rx_idle_cnt == RX_TIMEOUT_CLKS - 1);

	// silence counter, restarted by every byte
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			rx_idle_cnt <= '0;
		else if (rx_state == RX_IDLE || byte_valid)
			rx_idle_cnt <= '0;
		else
			rx_idle_cnt <= rx_idle_cnt + 1'b1;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_state      <= RX_IDLE;
			rx_cnt        <= '0;
			bus.rx_length <= '0;
			bus.rx_done   <= 1'b0;
		end else begin
			bus.rx_done <= 1'b0;
			if (byte_valid) begin
				case (rx_state)
					RX_IDLE:  if (byte_data == BRACE_OPEN) rx_state <= RX_OPEN1;
					RX_OPEN1: if (byte_data == BRACE_OPEN) rx_state <= RX_SKIP;
					// first byte after the opening pair is thrown away
					RX_SKIP: begin
						rx_state <= RX_CONTENT;
						rx_cnt   <= '0;
					end
					RX_CONTENT: begin
						if (byte_data == BRACE_CLOSE)
							rx_state <= RX_CLOSE1;
						else if (rx_cnt < MAX_STR_BYTES)
							rx_cnt <= rx_cnt + 1'b1;
					end
					RX_CLOSE1: begin
						if (byte_data == BRACE_CLOSE) begin
							rx_state      <= RX_IDLE;
							bus.rx_length <= rx_cnt;
							bus.rx_done   <= 1'b1;
						end else begin
							// lone close brace stays in the payload
							rx_state <= RX_CONTENT;
							rx_cnt   <= (rx_cnt < MAX_STR_BYTES - 1) ?
							            rx_cnt + LEN_BITS'(2) : LEN_BITS'(MAX_STR_BYTES);
						end
					end
					default: rx_state <= RX_IDLE;
				endcase
			end else if (rx_timeout) begin
				rx_state <= RX_IDLE;
			end
		end
	end

	// working buffer and the published copy
	always_ff @(posedge sys_clk) begin
		if (byte_valid) begin
			case (rx_state)
				RX_SKIP: rx_buf.flat <= '0;
				RX_CONTENT: begin
					if (byte_data != BRACE_CLOSE && rx_cnt < MAX_STR_BYTES)
						rx_buf.bytes[rx_wr_idx] <= byte_data;
				end
				RX_CLOSE1: begin
					if (byte_data == BRACE_CLOSE) begin
						bus.rx_string <= rx_buf.flat;
					end else begin
						if (rx_cnt < MAX_STR_BYTES)
							rx_buf.bytes[rx_wr_idx] <= BRACE_CLOSE;
						if (rx_cnt < MAX_STR_BYTES - 1)
							rx_buf.bytes[rx_wr_idx + 1'b1] <= byte_data;
					end
				end
				default: ;
			endcase
		end
	end

	uart_bit_tx u_bit_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.data      (bit_data),
		.start     (bit_start),
		.txd       (uart_tx),
		.done      (bit_done)
	);

	uart_bit_rx u_bit_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (uart_rx),
		.data      (byte_data),
		.valid     (byte_valid)
	);

endmodule

//--- logic/str_collect.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// received frame collector
// pending flags, round-robin pick
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module str_collect
	import uart_str_pkg::*;
(
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	str_chan_if.coll            bus [NUM_CH],
	output logic                rx_valid,
	output logic [CH_BITS-1:0]  rx_ch,
	output logic [STR_BITS-1:0] rx_string,
	output logic [LEN_BITS-1:0] rx_length
);

	logic [STR_BITS-1:0] ch_string [NUM_CH];
	logic [LEN_BITS-1:0] ch_length [NUM_CH];
	logic [NUM_CH-1:0]   ch_done;
	logic [NUM_CH-1:0]   pending;
	logic [NUM_CH-1:0]   clear_mask;
	logic [CH_BITS-1:0]  rr_ptr;
	logic [CH_BITS-1:0]  sel_ch;
	logic                sel_found;

	for (genvar g = 0; g < NUM_CH; g++) begin : g_gather
		assign ch_string[g] = bus[g].rx_string;
		assign ch_length[g] = bus[g].rx_length;
		assign ch_done[g]   = bus[g].rx_done;
	end

	// first pending channel at or after the pointer
	always_comb begin
		logic [CH_BITS-1:0] cand;
		sel_found = 1'b0;
		sel_ch    = rr_ptr;
		for (int k = 0; k < NUM_CH; k++) begin
			cand = CH_BITS'((int'(rr_ptr) + k) % NUM_CH);
			if (!sel_found && pending[cand]) begin
				sel_found = 1'b1;
				sel_ch    = cand;
			end
		end
	end

	assign clear_mask = sel_found ? (NUM_CH'(1) << sel_ch) : '0;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			pending   <= '0;
			rr_ptr    <= '0;
			rx_valid  <= 1'b0;
			rx_ch     <= '0;
			rx_length <= '0;
		end else begin
			// a frame finishing now is what the channel already shows
			pending  <= (pending | ch_done) & ~clear_mask;
			rx_valid <= sel_found;
			if (sel_found) begin
				rx_ch     <= sel_ch;
				rx_length <= ch_length[sel_ch];
				rr_ptr    <= CH_BITS'((int'(sel_ch) + 1) % NUM_CH);
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sel_found)
			rx_string <= ch_string[sel_ch];
	end

endmodule

//--- logic/str_dispatch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// transmit request router
// per channel request, busy and done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module str_dispatch
	import uart_str_pkg::*;
(
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  logic [CH_BITS-1:0]  tx_ch,
	input  logic [STR_BITS-1:0] tx_string,
	input  logic [LEN_BITS-1:0] tx_length,
	input  logic                tx_req,
	output logic [NUM_CH-1:0]   tx_busy,
	output logic [NUM_CH-1:0]   tx_done,
	str_chan_if.disp            bus [NUM_CH]
);

	logic [NUM_CH-1:0] accept;

	for (genvar g = 0; g < NUM_CH; g++) begin : g_route
		// empty strings and busy targets never reach a channel
		assign accept[g] = tx_req && (tx_ch == CH_BITS'(g)) &&
		                   !bus[g].tx_busy && (tx_length != '0);

		assign bus[g].tx_req    = accept[g];
		assign bus[g].tx_string = tx_string;
		assign bus[g].tx_length = tx_length;

		assign tx_busy[g] = bus[g].tx_busy;
		assign tx_done[g] = bus[g].tx_done;
	end

endmodule

//--- logic/uart_bit_rx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// serial byte receiver, 8N1
// two flop synchronizer, mid-bit sampling
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module uart_bit_rx
	import uart_str_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rxd,
	output logic [7:0] data,
	output logic       valid
);

	logic                            rxd_meta;
	logic                            rxd_sync;
	logic                            rxd_prev;
	logic                            busy;
	logic [3:0]                      bit_idx;
	logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt;
	logic                            sample;

	assign sample = busy && (baud_cnt == CLKS_PER_BIT / 2 - 1);

	// idle line is high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy     <= 1'b0;
			bit_idx  <= '0;
			baud_cnt <= '0;
			valid    <= 1'b0;
		end else begin
			valid <= 1'b0;
			if (!busy) begin
				// falling edge opens a byte
				if (rxd_prev && !rxd_sync) begin
					busy     <= 1'b1;
					bit_idx  <= '0;
					baud_cnt <= '0;
				end
			end else begin
				baud_cnt <= (baud_cnt == CLKS_PER_BIT - 1) ? '0 : baud_cnt + 1'b1;
				if (sample) begin
					if (bit_idx == 4'd0 && rxd_sync) begin
						// glitch, start bit gone by mid-bit
						busy <= 1'b0;
					end else if (bit_idx == 4'd9) begin
						busy  <= 1'b0;
						valid <= rxd_sync;
					end else begin
						bit_idx <= bit_idx + 4'd1;
					end
				end
			end
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge sys_clk) begin
		if (sample && bit_idx != 4'd0 && bit_idx != 4'd9)
			data <= {rxd_sync, data[7:1]};
	end

endmodule

//--- logic/uart_bit_tx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// serial byte transmitter, 8N1
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module uart_bit_tx
	import uart_str_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] data,
	input  logic       start,
	output logic       txd,
	output logic       done
);

	logic                            busy;
	logic [3:0]                      bit_idx;
	logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt;
	logic [9:0]                      frame_sr;
	logic                            bit_end;

	assign bit_end = (baud_cnt == CLKS_PER_BIT - 1);

	// bit 0 is the start bit, bit 9 the stop bit
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy     <= 1'b0;
			bit_idx  <= '0;
			baud_cnt <= '0;
			done     <= 1'b0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				if (start) begin
					busy     <= 1'b1;
					bit_idx  <= '0;
					baud_cnt <= '0;
				end
			end else if (bit_end) begin
				baud_cnt <= '0;
				if (bit_idx == 4'd9) begin
					busy <= 1'b0;
					done <= 1'b1;
				end else begin
					bit_idx <= bit_idx + 4'd1;
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// lsb first, ones fill in from the top
	always_ff @(posedge sys_clk) begin
		if (!busy && start)
			frame_sr <= {1'b1, data, 1'b0};
		else if (busy && bit_end)
			frame_sr <= {1'b1, frame_sr[9:1]};
	end

	assign txd = busy ? frame_sr[0] : 1'b1;

endmodule

//--- logic/uart_str_hub.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two channel uart string hub, top level
// channel array, dispatcher, collector
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module uart_str_hub
	import uart_str_pkg::*;
(
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  logic [CH_BITS-1:0]  tx_ch,
	input  logic [STR_BITS-1:0] tx_string,
	input  logic [LEN_BITS-1:0] tx_length,
	input  logic                tx_req,
	input  logic [NUM_CH-1:0]   uart_rx,
	output logic [NUM_CH-1:0]   tx_busy,
	output logic [NUM_CH-1:0]   tx_done,
	output logic                rx_valid,
	output logic [CH_BITS-1:0]  rx_ch,
	output logic [STR_BITS-1:0] rx_string,
	output logic [LEN_BITS-1:0] rx_length,
	output logic [NUM_CH-1:0]   uart_tx
);

	str_chan_if chan_bus [NUM_CH] ();

	for (genvar g = 0; g < NUM_CH; g++) begin : g_chan
		str_channel u_chan (
			.sys_clk   (sys_clk),
			.sys_rst_n (sys_rst_n),
			.bus       (chan_bus[g]),
			.uart_rx   (uart_rx[g]),
			.uart_tx   (uart_tx[g])
		);
	end

	str_dispatch u_dispatch (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_ch     (tx_ch),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.bus       (chan_bus)
	);

	// one frame per cycle onto the shared output
	str_collect u_collect (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.bus       (chan_bus),
		.rx_valid  (rx_valid),
		.rx_ch     (rx_ch),
		.rx_string (rx_string),
		.rx_length (rx_length)
	);

endmodule

//--- logic/uart_str_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared constants of the string hub
// marker bytes, fsm state codes and the
// string buffer union
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package uart_str_pkg;

	localparam int NUM_CH          = 2;
	localparam int MAX_STR_BYTES   = 16;
	localparam int STR_BITS        = 128;
	localparam int LEN_BITS        = 5;
	localparam int CH_BITS         = 1;
	localparam int CLKS_PER_BIT    = 16;
	localparam int RX_TIMEOUT_CLKS = 400;

	localparam logic [7:0] BRACE_OPEN  = 8'h7B;
	localparam logic [7:0] BRACE_CLOSE = 8'h7D;

	// transmit framing, one state per byte kind on the line
	localparam logic [2:0] TX_IDLE    = 3'd0;
	localparam logic [2:0] TX_OPEN1   = 3'd1;
	localparam logic [2:0] TX_OPEN2   = 3'd2;
	localparam logic [2:0] TX_CONTENT = 3'd3;
	localparam logic [2:0] TX_CLOSE1  = 3'd4;
	localparam logic [2:0] TX_CLOSE2  = 3'd5;

	// receive parsing
	localparam logic [2:0] RX_IDLE    = 3'd0;
	localparam logic [2:0] RX_OPEN1   = 3'd1;
	localparam logic [2:0] RX_SKIP    = 3'd2;
	localparam logic [2:0] RX_CONTENT = 3'd3;
	localparam logic [2:0] RX_CLOSE1  = 3'd4;

	// byte 0 sits in the low bits and goes out first
	typedef union packed {
		logic [STR_BITS-1:0]           flat;
		logic [MAX_STR_BYTES-1:0][7:0] bytes;
	} str_buf_u;

endpackage

//--- run_sim.sh
#!/bin/sh
# build the string hub testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_uart_str_hub \
	-f compile.f -o sim_hub > build.log 2>&1 \
	&& ./obj_dir/sim_hub > sim.log 2>&1 \
	|| { echo "build or run error, see build.log and sim.log"; exit 1; }

grep -q "Simulation PASSED" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

//--- sim/hub_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// received frame checker
// stream parser model, per channel
// queues of expected frames, compare
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module hub_checker
	import uart_str_pkg::*;
(
	input logic                sys_clk,
	input logic                sys_rst_n,
	input logic                rx_valid,
	input logic [CH_BITS-1:0]  rx_ch,
	input logic [STR_BITS-1:0] rx_string,
	input logic [LEN_BITS-1:0] rx_length
);

	typedef logic [LEN_BITS+STR_BITS-1:0] frame_t;

	frame_t exp_q0 [$];
	frame_t exp_q1 [$];
	int     err_cnt     = 0;
	int     frames_seen = 0;

	// first complete frame found in a raw byte stream
	function automatic void parse_stream(
		input  logic [7:0]          stream [$],
		output logic [STR_BITS-1:0] str,
		output logic [LEN_BITS-1:0] len,
		output bit                  found
	);
		logic [MAX_STR_BYTES-1:0][7:0] kept;
		logic [7:0]                    b;
		int                            opens;
		int                            st;
		int                            n;
		kept  = '0;
		opens = 0;
		st    = 0;
		n     = 0;
		found = 1'b0;
		for (int i = 0; i < stream.size() && !found; i++) begin
			b = stream[i];
			case (st)
				// hunt for two open braces, anything else ignored
				0: if (b == BRACE_OPEN) begin
					opens++;
					if (opens == 2)
						st = 1;
				end
				// byte right after the opening pair is lost
				1: st = 2;
				2: if (b == BRACE_CLOSE) begin
					st = 3;
				end else if (n < MAX_STR_BYTES) begin
					kept[n] = b;
					n++;
				end
				default: if (b == BRACE_CLOSE) begin
					found = 1'b1;
				end else begin
					// lone close brace kept as payload
					if (n < MAX_STR_BYTES) begin
						kept[n] = BRACE_CLOSE;
						n++;
					end
					if (n < MAX_STR_BYTES) begin
						kept[n] = b;
						n++;
					end
					st = 2;
				end
			endcase
		end
		str = kept;
		len = LEN_BITS'(n);
	endfunction

	function automatic void add_expected(input int ch, input logic [7:0] stream [$]);
		logic [STR_BITS-1:0] str;
		logic [LEN_BITS-1:0] len;
		bit                  found;
		parse_stream(stream, str, len, found);
		if (found && ch == 0)
			exp_q0.push_back({len, str});
		else if (found)
			exp_q1.push_back({len, str});
	endfunction

	function automatic int frames_left();
		return exp_q0.size() + exp_q1.size();
	endfunction

	// outputs are registered, so mid-cycle sampling is stable
	always @(negedge sys_clk) begin
		frame_t exp;
		int     own_left;
		int     other_left;
		if (sys_rst_n && rx_valid) begin
			frames_seen++;
			own_left   = (rx_ch == 0) ? exp_q0.size() : exp_q1.size();
			other_left = (rx_ch == 0) ? exp_q1.size() : exp_q0.size();
			if (own_left == 0 && other_left != 0) begin
				$display("[FAIL] rx_ch got %h expected %h", rx_ch, ~rx_ch);
				err_cnt++;
				if (rx_ch == 0)
					void'(exp_q1.pop_front());
				else
					void'(exp_q0.pop_front());
			end else if (own_left == 0) begin
				$display("frame on channel %0d arrived while none was expected", rx_ch);
				err_cnt++;
			end else begin
				if (rx_ch == 0)
					exp = exp_q0.pop_front();
				else
					exp = exp_q1.pop_front();
				if (rx_string !== exp[STR_BITS-1:0]) begin
					$display("[FAIL] rx_string got %h expected %h", rx_string,
					         exp[STR_BITS-1:0]);
					err_cnt++;
				end
				if (rx_length !== exp[STR_BITS +: LEN_BITS]) begin
					$display("[FAIL] rx_length got %h expected %h", rx_length,
					         exp[STR_BITS +: LEN_BITS]);
					err_cnt++;
				end
			end
		end
	end

endmodule

//--- sim/hub_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// channel assertions, bound into
// every string channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module hub_sva
	import uart_str_pkg::*;
(
	input logic                sys_clk,
	input logic                sys_rst_n,
	input logic [2:0]          tx_state,
	input logic                tx_busy,
	input logic                tx_done,
	input logic                rx_done,
	input logic [LEN_BITS-1:0] rx_length,
	input logic                uart_tx
);

	// shortest frame is five bytes, so busy well before any tx_done
	done_after_frame: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |-> $past(tx_busy, 5 * 10 * CLKS_PER_BIT))
		else $error("tx_done without a full frame of busy before it");

	rx_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |=> !rx_done)
		else $error("rx_done held longer than one cycle");

	// idle line stays at the stop level
	line_idle_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!tx_busy |-> uart_tx)
		else $error("uart_tx low while the channel is not busy");

	length_capped: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_length <= MAX_STR_BYTES)
		else $error("rx_length above the payload capacity");

endmodule

bind str_channel hub_sva u_sva (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.tx_state  (tx_state),
	.tx_busy   (bus.tx_busy),
	.tx_done   (bus.tx_done),
	.rx_done   (bus.rx_done),
	.rx_length (bus.rx_length),
	.uart_tx   (uart_tx)
);

//--- sim/tb_clk_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock, 10 ns period
// reset held low for 4 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_clk_gen (
	output logic sys_clk,
	output logic sys_rst_n
);

	localparam int RST_CYCLES = 4;

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	initial begin
		sys_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;
	end

endmodule

//--- sim/tb_uart_str_hub.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// string hub testbench top
// loopback, serial injection, run limit,
// per test results and summary
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_uart_str_hub
	import uart_str_pkg::*;
();

	// 14 frames of 20 bytes at 161 cycles each, plus idle gaps
	localparam int TIMEOUT_CYCLES = 60000;
	localparam int SEED           = 26846;

	logic                sys_clk;
	logic                sys_rst_n;
	logic [CH_BITS-1:0]  tx_ch;
	logic [STR_BITS-1:0] tx_string;
	logic [LEN_BITS-1:0] tx_length;
	logic                tx_req;
	logic                rx0_line;
	logic [NUM_CH-1:0]   uart_rx;
	logic [NUM_CH-1:0]   uart_tx;
	logic [NUM_CH-1:0]   tx_busy;
	logic [NUM_CH-1:0]   tx_done;
	logic                rx_valid;
	logic [CH_BITS-1:0]  rx_ch;
	logic [STR_BITS-1:0] rx_string;
	logic [LEN_BITS-1:0] rx_length;
	logic [7:0]          stream_q [$];
	int                  done_cnt [NUM_CH] = '{default: 0};
	int                  cycle_cnt = 0;
	int                  tb_err    = 0;
	int                  err_mark  = 0;
	int                  test_cnt  = 0;
	int                  test_pass = 0;

	// channel 0 transmit loops back into channel 1
	assign uart_rx = {uart_tx[0], rx0_line};

	tb_clk_gen u_clk (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n)
	);

	uart_str_hub dut (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_ch     (tx_ch),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.uart_rx   (uart_rx),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.rx_valid  (rx_valid),
		.rx_ch     (rx_ch),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.uart_tx   (uart_tx)
	);

	hub_checker u_checker (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_valid  (rx_valid),
		.rx_ch     (rx_ch),
		.rx_string (rx_string),
		.rx_length (rx_length)
	);

	always @(posedge sys_clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("run stopped, no end after %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

	always @(negedge sys_clk) begin
		for (int i = 0; i < NUM_CH; i++)
			if (tx_done[i])
				done_cnt[i]++;
	end

	// printable bytes below the open brace only
	function automatic logic [STR_BITS-1:0] rand_payload();
		logic [STR_BITS-1:0] s;
		for (int i = 0; i < MAX_STR_BYTES; i++)
			s[i*8 +: 8] = 8'h20 + 8'($urandom % 91);
		return s;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			tb_err++;
		end
	endtask

	task automatic load_text(input string text);
		stream_q.delete();
		for (int i = 0; i < text.len(); i++)
			stream_q.push_back(text[i]);
	endtask

	task automatic inject_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rx0_line = bits[i];
			repeat (CLKS_PER_BIT) @(posedge sys_clk);
			#1;
		end
	endtask

	task automatic inject_stream(input bit expect_frame);
		if (expect_frame)
			u_checker.add_expected(0, stream_q);
		foreach (stream_q[i])
			inject_byte(stream_q[i]);
	endtask

	task automatic request(input int ch, input logic [STR_BITS-1:0] s, input int len);
		tx_ch     = CH_BITS'(ch);
		tx_string = s;
		tx_length = LEN_BITS'(len);
		tx_req    = 1'b1;
		@(posedge sys_clk);
		#1;
		tx_req = 1'b0;
	endtask

	// bytes channel 0 puts on the line, as seen by channel 1
	task automatic expect_loopback(input logic [STR_BITS-1:0] s, input int len);
		logic [7:0] line_q [$];
		line_q.push_back(BRACE_OPEN);
		line_q.push_back(BRACE_OPEN);
		for (int i = 0; i < len; i++)
			line_q.push_back(s[i*8 +: 8]);
		line_q.push_back(BRACE_CLOSE);
		line_q.push_back(BRACE_CLOSE);
		u_checker.add_expected(1, line_q);
	endtask

	task automatic wait_done_count(input int ch, input int target);
		while (done_cnt[ch] < target)
			@(posedge sys_clk);
		#1;
	endtask

	task automatic wait_drained();
		while (u_checker.frames_left() != 0)
			@(posedge sys_clk);
		repeat (4) @(posedge sys_clk);
		#1;
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = tb_err + u_checker.err_cnt;
		test_cnt++;
		if (errs == err_mark) begin
			test_pass++;
			$display("test %0d %s: ok", test_cnt, name);
		end else begin
			$display("test %0d %s: %0d errors", test_cnt, name, errs - err_mark);
		end
		err_mark = errs;
	endtask

	initial begin
		logic [STR_BITS-1:0] s;
		int                  len;
		int                  done_mark [NUM_CH];
		int                  errs;
		void'($urandom(SEED));
		tx_ch     = '0;
		tx_string = '0;
		tx_length = '0;
		tx_req    = 1'b0;
		rx0_line  = 1'b1;
		wait (sys_rst_n);
		@(posedge sys_clk);
		#1;

		// outputs right after reset
		check_value("tx_busy", 32'(tx_busy), 32'h0);
		check_value("tx_done", 32'(tx_done), 32'h0);
		check_value("rx_valid", 32'(rx_valid), 32'h0);
		check_value("uart_tx", 32'(uart_tx), 32'({NUM_CH{1'b1}}));
		end_test("reset values");

		// random payloads around the loop
		done_mark = done_cnt;
		for (int n = 0; n < 6; n++) begin
			s   = rand_payload();
			len = 1 + int'($urandom % 16);
			expect_loopback(s, len);
			request(0, s, len);
			wait_done_count(0, done_mark[0] + n + 1);
		end
		wait_drained();
		if (done_cnt[0] - done_mark[0] != 6) begin
			$display("%0d tx_done pulses for 6 requests", done_cnt[0] - done_mark[0]);
			tb_err++;
		end
		end_test("loopback");

		load_text("q{{Zab}cd}}");
		inject_stream(1'b1);
		load_text("{{!}x}y}}");
		inject_stream(1'b1);
		wait_drained();
		end_test("escapes and dropped byte");

		// empty strings never start, busy targets ignore the second request
		request(0, rand_payload(), 0);
		request(1, rand_payload(), 0);
		repeat (3) begin
			@(negedge sys_clk);
			if (tx_busy != '0) begin
				$display("a zero length request made a channel busy");
				tb_err++;
			end
		end
		@(posedge sys_clk);
		#1;
		done_mark = done_cnt;
		s = rand_payload();
		expect_loopback(s, 3);
		request(0, s, 3);
		request(1, rand_payload(), 2);
		// start bit one cycle after the request
		check_value("uart_tx[1]", 32'(uart_tx[1]), 32'h0);
		request(0, rand_payload(), 5);
		request(1, rand_payload(), 5);
		wait_done_count(1, done_mark[1] + 1);
		wait_done_count(0, done_mark[0] + 1);
		repeat (200) @(posedge sys_clk);
		#1;
		if (done_cnt[0] - done_mark[0] != 1 || done_cnt[1] - done_mark[1] != 1 ||
		    tx_busy != '0) begin
			$display("a busy channel took a second request");
			tb_err++;
		end
		check_value("uart_tx", 32'(uart_tx), 32'({NUM_CH{1'b1}}));
		wait_drained();
		end_test("ignored requests");

		load_text("{{#ab");
		inject_stream(1'b0);
		repeat (RX_TIMEOUT_CLKS + 100) @(posedge sys_clk);
		#1;
		load_text("{{.after}}");
		inject_stream(1'b1);
		wait_drained();
		end_test("rx timeout");

		load_text("{{-ABCDEFGHIJKLMNOPQRST}}");
		inject_stream(1'b1);
		wait_drained();
		end_test("overflow");

		// both channels finish within a few cycles of each other
		s = rand_payload();
		expect_loopback(s, 6);
		load_text("{{.abcde}}");
		fork
			request(0, s, 6);
			inject_stream(1'b1);
		join
		wait_drained();
		end_test("collection");

		errs = tb_err + u_checker.err_cnt;
		$display("summary: %0d tests, %0d passed, %0d failed, %0d frames checked, %0d errors",
		         test_cnt, test_pass, test_cnt - test_pass, u_checker.frames_seen, errs);
		if (errs == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
